// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= dcache_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@! grep -q "TESTS FAILED" $(LOG)
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

.PHONY: sim clean

// ==== build.f ====
src/dcache_pkg.sv
src/dcache_word_align.sv
src/dcache_plru.sv
src/dcache_data_store.sv
src/dcache_tag_store.sv
src/dcache_ctrl.sv
src/dcache_top.sv
verif/line_memory_model.sv
verif/dcache_tb.sv

// ==== src/dcache_ctrl.sv ====
// data cache controller
// request register, miss fsm (write-back then refill), array write strobes
`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; #(
    parameter int WAYS = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_valid,
    input  logic                 req_op,
    input  addr_u                req_addr,
    input  logic [WORD_BYTES-1:0] req_wstrb,
    input  word_t                req_wdata,
    input  load_type_e           req_load_type,
    input  logic [WAYS-1:0]      hit,
    input  logic                 victim_dirty,
    input  logic [TAG_WIDTH-1:0] victim_tag,
    input  line_t                victim_line,
    input  word_t                load_word,
    input  logic                 mem_rd_rdy,
    input  logic                 mem_ret_valid,
    input  logic                 mem_wr_rdy,
    input  logic                 mem_wr_done,
    output addr_u                lkp_addr,
    output logic                 lkp_op,
    output logic [WORD_BYTES-1:0] lkp_wstrb,
    output word_t                lkp_wdata,
    output load_type_e           lkp_load_type,
    output logic                 tag_we,
    output logic                 data_refill_we,
    output logic                 store_we,
    output logic                 lru_update,
    output logic                 busy,
    output word_t                rdata,
    output logic                 rdata_valid,
    output logic                 mem_rd_req,
    output addr_u                mem_rd_addr,
    output logic                 mem_wr_req,
    output addr_u                mem_wr_addr,
    output line_t                mem_wr_data
);

    typedef enum logic [2:0] {
        LOOKUP,
        MISSDIRTY,
        WRITEBACK,
        MISSCLEAN,
        REFILL,
        REFILLDONE
    } state_e;

    state_e state, state_next;
    logic   lkp_valid;
    logic   lookup_hit;

    assign lookup_hit = (state == LOOKUP) && lkp_valid && (|hit);

    // a miss holds the request until the retried lookup hits
    assign busy = lkp_valid && !lookup_hit;

    always_ff @(posedge clk) begin
        if (rst) begin
            lkp_valid <= 1'b0;
        end else if (!busy) begin
            lkp_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy) begin
            lkp_addr      <= req_addr;
            lkp_op        <= req_op;
            lkp_wstrb     <= req_wstrb;
            lkp_wdata     <= req_wdata;
            lkp_load_type <= req_load_type;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= LOOKUP;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            LOOKUP: begin
                if (lkp_valid && !(|hit)) begin
                    state_next = victim_dirty ? MISSDIRTY : MISSCLEAN;
                end
            end
            MISSDIRTY:  if (mem_wr_rdy)    state_next = WRITEBACK;
            WRITEBACK:  if (mem_wr_done)   state_next = MISSCLEAN;
            MISSCLEAN:  if (mem_rd_rdy)    state_next = REFILL;
            REFILL:     if (mem_ret_valid) state_next = REFILLDONE;
            REFILLDONE: state_next = LOOKUP;  // arrays settle, then retry
            default:    state_next = LOOKUP;
        endcase
    end

    assign store_we       = lookup_hit && lkp_op;
    assign lru_update     = lookup_hit;
    assign tag_we         = (state == REFILL) && mem_ret_valid;
    assign data_refill_we = (state == REFILL) && mem_ret_valid;

    assign rdata       = load_word;
    assign rdata_valid = lookup_hit && !lkp_op;

    assign mem_rd_req  = (state == MISSCLEAN);
    assign mem_wr_req  = (state == MISSDIRTY);
    assign mem_wr_data = victim_line;   // arrays are quiet during the miss

    always_comb begin
        mem_rd_addr.f.tag    = lkp_addr.f.tag;
        mem_rd_addr.f.index  = lkp_addr.f.index;
        mem_rd_addr.f.offset = '0;
    end

    // victim line lives at its own tag, same set
    always_comb begin
        mem_wr_addr.f.tag    = victim_tag;
        mem_wr_addr.f.index  = lkp_addr.f.index;
        mem_wr_addr.f.offset = '0;
    end

endmodule

// ==== src/dcache_data_store.sv ====
// data cache line store
// per-way line arrays, refill and store writes, hit and victim reads
`timescale 1ns/1ps

module dcache_data_store import dcache_pkg::*; #(
    parameter int WAYS = 4
) (
    input  logic                    clk,
    input  addr_u                   lkp_addr,
    input  logic [WAYS-1:0]         hit,
    input  logic [$clog2(WAYS)-1:0] victim_way,
    input  logic                    data_refill_we,
    input  logic                    store_we,
    input  line_t                   mem_ret_data,
    input  line_t                   merged_line,
    output line_t                   hit_line,
    output line_t                   victim_line
);

    localparam int SETS     = 1 << INDEX_WIDTH;
    localparam int WAY_BITS = $clog2(WAYS);

    line_t way_line [WAYS];

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        line_t line_mem [SETS];

        always_ff @(posedge clk) begin
            if (data_refill_we && victim_way == WAY_BITS'(w)) begin
                line_mem[lkp_addr.f.index] <= mem_ret_data;
            end else if (store_we && hit[w]) begin
                line_mem[lkp_addr.f.index] <= merged_line;
            end
        end

        assign way_line[w] = line_mem[lkp_addr.f.index];
    end

    // hit is one-hot, so an or of the masked ways is enough
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (hit[w]) hit_line = hit_line | way_line[w];
        end
    end

    assign victim_line = way_line[victim_way];

endmodule

// ==== src/dcache_pkg.sv ====
// data cache package
// fixed line and address geometry, the address decode union,
// word and line types and the load type encoding
package dcache_pkg;

    localparam int WORD_BYTES   = 4;
    localparam int LINE_WORDS   = 4;
    localparam int OFFSET_WIDTH = $clog2(LINE_WORDS * WORD_BYTES);  // 4
    localparam int INDEX_WIDTH  = 6;                                 // 64 sets
    localparam int TAG_WIDTH    = 32 - INDEX_WIDTH - OFFSET_WIDTH;   // 22

    typedef logic [8*WORD_BYTES-1:0] word_t;

    // word 0 sits in the low bits
    typedef word_t [LINE_WORDS-1:0] line_t;

    typedef struct packed {
        logic [TAG_WIDTH-1:0]    tag;
        logic [INDEX_WIDTH-1:0]  index;
        logic [OFFSET_WIDTH-1:0] offset;
    } addr_fields_t;

    // raw view for the cpu and memory ports, field view for the arrays
    typedef union packed {
        logic [31:0]  raw;
        addr_fields_t f;
    } addr_u;

    typedef enum logic [2:0] {
        LT_LB,
        LT_LBU,
        LT_LH,
        LT_LHU,
        LT_LW
    } load_type_e;

endpackage

// ==== src/dcache_plru.sv ====
// tree pseudo-lru, WAYS-1 bits per set
// node n has children 2n+1 and 2n+2; a set bit points the victim right
`timescale 1ns/1ps

module dcache_plru import dcache_pkg::*; #(
    parameter int WAYS = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  addr_u                   lkp_addr,
    input  logic [WAYS-1:0]         hit,
    input  logic                    lru_update,
    output logic [$clog2(WAYS)-1:0] victim_way
);

    localparam int SETS     = 1 << INDEX_WIDTH;
    localparam int WAY_BITS = $clog2(WAYS);

    logic [WAYS-2:0]     tree [SETS];
    logic [WAYS-2:0]     tree_cur;
    logic [WAYS-2:0]     tree_next;
    logic [WAY_BITS-1:0] hit_way;

    assign tree_cur = tree[lkp_addr.f.index];

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (hit[w]) hit_way = WAY_BITS'(w);
        end
    end

    // walk the path of the hitting way, flip each node away from it
    always_comb begin
        int node;
        node      = 0;
        tree_next = tree_cur;
        for (int l = 0; l < WAY_BITS; l++) begin
            tree_next[node] = ~hit_way[WAY_BITS-1-l];
            node = 2 * node + 1 + int'(hit_way[WAY_BITS-1-l]);
        end
    end

    // follow the bits down to a leaf
    always_comb begin
        int node;
        int way;
        node = 0;
        way  = 0;
        for (int l = 0; l < WAY_BITS; l++) begin
            way  = 2 * way + int'(tree_cur[node]);
            node = 2 * node + 1 + int'(tree_cur[node]);
        end
        victim_way = WAY_BITS'(way);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                tree[s] <= '0;
            end
        end else if (lru_update) begin
            tree[lkp_addr.f.index] <= tree_next;
        end
    end

endmodule

// ==== src/dcache_tag_store.sv ====
// data cache tag store
// per-way valid, tag and dirty bits; hit compare and victim lookup
`timescale 1ns/1ps

module dcache_tag_store import dcache_pkg::*; #(
    parameter int WAYS = 4
) (
    input  logic                      clk,
    input  logic                      rst,
    input  addr_u                     lkp_addr,
    input  logic [$clog2(WAYS)-1:0]   victim_way,
    input  logic                      tag_we,
    input  logic                      store_we,
    output logic [WAYS-1:0]           hit,
    output logic                      victim_dirty,
    output logic [TAG_WIDTH-1:0]      victim_tag
);

    localparam int SETS     = 1 << INDEX_WIDTH;
    localparam int WAY_BITS = $clog2(WAYS);

    logic [WAYS-1:0]      way_valid;
    logic [WAYS-1:0]      way_dirty;
    logic [TAG_WIDTH-1:0] way_tag [WAYS];

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        logic [SETS-1:0]      valid_q;
        logic [SETS-1:0]      dirty_q;
        logic [TAG_WIDTH-1:0] tag_mem [SETS];

        always_ff @(posedge clk) begin
            if (rst) begin
                valid_q <= '0;
                dirty_q <= '0;
            end else if (tag_we && victim_way == WAY_BITS'(w)) begin
                valid_q[lkp_addr.f.index] <= 1'b1;   // fresh line is clean
                dirty_q[lkp_addr.f.index] <= 1'b0;
            end else if (store_we && hit[w]) begin
                dirty_q[lkp_addr.f.index] <= 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (tag_we && victim_way == WAY_BITS'(w)) begin
                tag_mem[lkp_addr.f.index] <= lkp_addr.f.tag;
            end
        end

        assign way_valid[w] = valid_q[lkp_addr.f.index];
        assign way_dirty[w] = dirty_q[lkp_addr.f.index];
        assign way_tag[w]   = tag_mem[lkp_addr.f.index];
        assign hit[w]       = way_valid[w] && (way_tag[w] == lkp_addr.f.tag);
    end

    assign victim_dirty = way_valid[victim_way] && way_dirty[victim_way];
    assign victim_tag   = way_tag[victim_way];

endmodule

// ==== src/dcache_top.sv ====
// write-back set-associative data cache
// blocking, one lookup cycle, tree pseudo-lru replacement
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; #(
    parameter int WAYS = 4
) (
    input  logic       clk,
    input  logic       rst,

    // cpu side
    input  logic       req_valid,
    input  logic       req_op,          // 1 = store
    input  addr_u      req_addr,
    input  logic [3:0] req_wstrb,
    input  word_t      req_wdata,
    input  load_type_e req_load_type,
    output logic       busy,
    output word_t      rdata,
    output logic       rdata_valid,

    // memory side, whole lines
    output logic       mem_rd_req,
    output addr_u      mem_rd_addr,
    input  logic       mem_rd_rdy,
    input  logic       mem_ret_valid,
    input  line_t      mem_ret_data,
    output logic       mem_wr_req,
    output addr_u      mem_wr_addr,
    output line_t      mem_wr_data,
    input  logic       mem_wr_rdy,
    input  logic       mem_wr_done
);

    localparam int WAY_BITS = $clog2(WAYS);

    addr_u                 lkp_addr;
    logic                  lkp_op;
    logic [3:0]            lkp_wstrb;
    word_t                 lkp_wdata;
    load_type_e            lkp_load_type;
    logic                  tag_we;
    logic                  data_refill_we;
    logic                  store_we;
    logic                  lru_update;
    logic [WAYS-1:0]       hit;
    logic                  victim_dirty;
    logic [TAG_WIDTH-1:0]  victim_tag;
    logic [WAY_BITS-1:0]   victim_way;
    line_t                 hit_line;
    line_t                 victim_line;
    word_t                 load_word;
    line_t                 merged_line;

    dcache_ctrl #(.WAYS(WAYS)) u_ctrl (
        .clk, .rst,
        .req_valid, .req_op, .req_addr, .req_wstrb, .req_wdata, .req_load_type,
        .hit, .victim_dirty, .victim_tag, .victim_line, .load_word,
        .mem_rd_rdy, .mem_ret_valid, .mem_wr_rdy, .mem_wr_done,
        .lkp_addr, .lkp_op, .lkp_wstrb, .lkp_wdata, .lkp_load_type,
        .tag_we, .data_refill_we, .store_we, .lru_update,
        .busy, .rdata, .rdata_valid,
        .mem_rd_req, .mem_rd_addr, .mem_wr_req, .mem_wr_addr, .mem_wr_data
    );

    dcache_tag_store #(.WAYS(WAYS)) u_tag_store (
        .clk, .rst, .lkp_addr, .victim_way, .tag_we, .store_we,
        .hit, .victim_dirty, .victim_tag
    );

    dcache_data_store #(.WAYS(WAYS)) u_data_store (
        .clk, .lkp_addr, .hit, .victim_way, .data_refill_we, .store_we,
        .mem_ret_data, .merged_line, .hit_line, .victim_line
    );

    dcache_plru #(.WAYS(WAYS)) u_plru (
        .clk, .rst, .lkp_addr, .hit, .lru_update, .victim_way
    );

    dcache_word_align u_word_align (
        .lkp_addr, .lkp_load_type, .lkp_wstrb, .lkp_wdata, .hit_line,
        .load_word, .merged_line
    );

endmodule

// ==== src/dcache_word_align.sv ====
// word select and load extension from the hit line,
// plus the byte-strobe merge of store data into that line
`timescale 1ns/1ps

module dcache_word_align import dcache_pkg::*; (
    input  addr_u                 lkp_addr,
    input  load_type_e            lkp_load_type,
    input  logic [WORD_BYTES-1:0] lkp_wstrb,
    input  word_t                 lkp_wdata,
    input  line_t                 hit_line,
    output word_t                 load_word,
    output line_t                 merged_line
);

    localparam int BYTE_BITS = $clog2(WORD_BYTES);

    logic [OFFSET_WIDTH-BYTE_BITS-1:0] word_sel;
    logic [BYTE_BITS-1:0]              byte_sel;
    word_t                             sel_word;
    word_t                             merged_word;
    logic [7:0]                        sel_byte;
    logic [15:0]                       sel_half;

    assign word_sel = lkp_addr.f.offset[OFFSET_WIDTH-1:BYTE_BITS];
    assign byte_sel = lkp_addr.f.offset[BYTE_BITS-1:0];
    assign sel_word = hit_line[word_sel];
    assign sel_byte = sel_word[8*byte_sel +: 8];
    assign sel_half = sel_word[16*byte_sel[BYTE_BITS-1] +: 16];  // offset bit 0 ignored

    always_comb begin
        case (lkp_load_type)
            LT_LB:   load_word = word_t'($signed(sel_byte));
            LT_LBU:  load_word = word_t'(sel_byte);
            LT_LH:   load_word = word_t'($signed(sel_half));
            LT_LHU:  load_word = word_t'(sel_half);
            default: load_word = sel_word;                    // lw
        endcase
    end

    always_comb begin
        merged_word = sel_word;
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (lkp_wstrb[b]) merged_word[8*b +: 8] = lkp_wdata[8*b +: 8];
        end
        merged_line           = hit_line;
        merged_line[word_sel] = merged_word;
    end

endmodule

// ==== verif/dcache_stimulus.txt ====
// op(0 load,1 store) type(0 lb,1 lbu,2 lh,3 lhu,4 lw) addr strobe wdata expected
// flag: 1 load must hit, 2 request must miss, 0 no timing check; op ff ends the list
0 4 00000000 0 00000000 00000000 2
0 4 00000004 0 00000000 00000000 1
1 4 00000000 f 8badf00d 00000000 1
0 4 00000000 0 00000000 8badf00d 1
0 0 00000000 0 00000000 0000000d 1
0 0 00000001 0 00000000 fffffff0 1
0 0 00000002 0 00000000 ffffffad 1
0 0 00000003 0 00000000 ffffff8b 1
0 1 00000000 0 00000000 0000000d 1
0 1 00000001 0 00000000 000000f0 1
0 1 00000002 0 00000000 000000ad 1
0 1 00000003 0 00000000 0000008b 1
0 2 00000000 0 00000000 fffff00d 1
0 2 00000002 0 00000000 ffff8bad 1
0 3 00000000 0 00000000 0000f00d 1
0 3 00000002 0 00000000 00008bad 1
1 4 00000004 3 12345678 00000000 0
0 4 00000004 0 00000000 00005678 1
1 4 00000004 8 aa000000 00000000 0
0 4 00000004 0 00000000 aa005678 1
1 4 00000008 4 00c30000 00000000 0
0 4 00000008 0 00000000 00c30000 1
1 4 00000400 f 11111111 00000000 2
1 4 00000800 f 22222222 00000000 2
1 4 00000c00 f 33333333 00000000 2
1 4 00001000 f 44444444 00000000 2
1 4 00001400 f 55555555 00000000 2
1 4 00001800 f 66666666 00000000 2
0 1 00000401 0 00000000 00000011 0
0 4 00000000 0 00000000 8badf00d 0
0 4 00000004 0 00000000 aa005678 0
0 4 00000008 0 00000000 00c30000 0
0 4 00000400 0 00000000 11111111 0
0 4 00000800 0 00000000 22222222 0
0 4 00000c00 0 00000000 33333333 0
0 4 00001000 0 00000000 44444444 0
0 4 00001400 0 00000000 55555555 0
0 4 00001800 0 00000000 66666666 0
0 2 00001802 0 00000000 00006666 0
ff 0 00000000 0 00000000 00000000 0

// ==== verif/dcache_tb.sv ====
// data cache testbench
// replays requests from the stimulus file, keeps a golden word memory
// and checks load results, refill addresses and every write-back line
`timescale 1ns/1ps

module dcache_tb import dcache_pkg::*; ();

    localparam int WAYS    = 4;
    localparam int MAX_REQ = 64;
    localparam int FIELDS  = 7;     // op, type, addr, strobe, wdata, expected, flag
    localparam int TIMEOUT = 200;

    logic       clk;
    logic       rst;
    logic       req_valid;
    logic       req_op;
    addr_u      req_addr;
    logic [3:0] req_wstrb;
    word_t      req_wdata;
    load_type_e req_load_type;
    logic       busy;
    word_t      rdata;
    logic       rdata_valid;
    logic       mem_rd_req;
    addr_u      mem_rd_addr;
    logic       mem_rd_rdy;
    logic       mem_ret_valid;
    line_t      mem_ret_data;
    logic       mem_wr_req;
    addr_u      mem_wr_addr;
    line_t      mem_wr_data;
    logic       mem_wr_rdy;
    logic       mem_wr_done;

    logic [31:0] stim [0:MAX_REQ*FIELDS-1];
    word_t       golden [logic [29:0]];
    line_t       wb_golden;
    addr_u       refill_exp;
    int          rd_count;
    int          checks;
    int          errors;
    int          n;

    dcache_top #(.WAYS(WAYS)) u_dut (.*);

    line_memory_model u_mem (
        .clk, .rst,
        .rd_req(mem_rd_req), .rd_addr(mem_rd_addr), .rd_rdy(mem_rd_rdy),
        .ret_valid(mem_ret_valid), .ret_data(mem_ret_data),
        .wr_req(mem_wr_req), .wr_addr(mem_wr_addr), .wr_data(mem_wr_data),
        .wr_rdy(mem_wr_rdy), .wr_done(mem_wr_done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_line(input string name, input line_t exp, input line_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input addr_u exp, input addr_u act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s expected %h actual %h", name, exp.raw, act.raw);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s did not happen within %0d cycles", what, TIMEOUT);
        $display("TESTS FAILED");
        $finish;
    endtask

    function automatic word_t golden_read(input logic [31:0] a);
        return golden.exists(a[31:2]) ? golden[a[31:2]] : '0;
    endfunction

    // drive one request at a falling edge, return at the falling edge where it is done
    task automatic run_request(input int idx);
        int    base;
        int    waited;
        int    rd_before;
        logic  [31:0] flag;
        word_t expect_val;
        word_t mask;
        string name;
        base          = idx * FIELDS;
        req_valid     = 1'b1;
        req_op        = stim[base][0];
        req_load_type = load_type_e'(stim[base+1][2:0]);
        req_addr.raw  = stim[base+2];
        req_wstrb     = stim[base+3][3:0];
        req_wdata     = stim[base+4];
        expect_val    = stim[base+5];
        flag          = stim[base+6];
        name = $sformatf("req %0d at %h", idx, req_addr.raw);
        waited = 0;
        while (busy) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) report_timeout("acceptance of a request");
        end
        rd_before = rd_count;
        @(posedge clk);   // accepted here
        if (req_op) begin
            mask = {{8{req_wstrb[3]}}, {8{req_wstrb[2]}}, {8{req_wstrb[1]}}, {8{req_wstrb[0]}}};
            golden[req_addr.raw[31:2]] = (golden_read(req_addr.raw) & ~mask) | (req_wdata & mask);
        end
        @(negedge clk);
        req_valid = 1'b0;
        if (!req_op) begin
            if (flag == 1 && !rdata_valid) begin
                errors++;
                $display("%s: load hit did not return one cycle after acceptance", name);
            end
            waited = 0;
            while (!rdata_valid) begin
                @(negedge clk);
                waited++;
                if (waited > TIMEOUT) report_timeout("load result");
            end
            check_word(name, expect_val, rdata);
            if (req_load_type == LT_LW) begin
                check_word({name, " vs golden"}, golden_read(req_addr.raw), rdata);
            end
        end else begin
            waited = 0;
            while (busy) begin
                @(negedge clk);
                waited++;
                if (waited > TIMEOUT) report_timeout("end of a store miss");
            end
        end
        if (flag == 2 && rd_count == rd_before) begin
            errors++;
            $display("%s: expected a miss but no refill was requested", name);
        end
    endtask

    // refill count and address, write-back line check
    always @(posedge clk) begin
        if (!rst && mem_rd_req && mem_rd_rdy) begin
            rd_count++;
            refill_exp.raw = {req_addr.raw[31:OFFSET_WIDTH], OFFSET_WIDTH'(0)};
            check_addr("refill address", refill_exp, mem_rd_addr);
        end
        if (!rst && mem_wr_req && mem_wr_rdy) begin
            for (int w = 0; w < LINE_WORDS; w++) begin
                wb_golden[w] = golden_read(mem_wr_addr.raw + 32'(4 * w));
            end
            check_line($sformatf("write-back %h", mem_wr_addr.raw), wb_golden, mem_wr_data);
        end
    end

    initial begin
        rst           = 1'b1;
        req_valid     = 1'b0;
        req_op        = 1'b0;
        req_addr      = '0;
        req_wstrb     = '0;
        req_wdata     = '0;
        req_load_type = LT_LW;
        rd_count      = 0;
        checks        = 0;
        errors        = 0;
        $readmemh("verif/dcache_stimulus.txt", stim);
        repeat (3) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        if (busy !== 1'b0 || rdata_valid !== 1'b0 || mem_rd_req !== 1'b0
                || mem_wr_req !== 1'b0) begin
            errors++;
            $display("outputs are not idle after reset");
        end
        n = 0;
        while (n < MAX_REQ && stim[n*FIELDS] != 32'h0000_00ff) begin
            run_request(n);
            n++;
        end
        $display("requests: %0d, checks: %0d, errors: %0d", n, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== verif/line_memory_model.sv ====
// line-wide backing memory for the data cache testbench
// answers refills and write-backs after short random delays
`timescale 1ns/1ps

module line_memory_model import dcache_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  rd_req,
    input  addr_u rd_addr,
    output logic  rd_rdy,
    output logic  ret_valid,
    output line_t ret_data,
    input  logic  wr_req,
    input  addr_u wr_addr,
    input  line_t wr_data,
    output logic  wr_rdy,
    output logic  wr_done
);

    line_t mem [logic [27:0]];   // keyed by line address, empty lines read as zero
    int    seed = 32'h5911_ae67;

    // zero to three idle cycles
    task automatic random_wait();
        int n;
        n = $unsigned($random(seed)) % 4;
        repeat (n) @(negedge clk);
    endtask

    initial begin
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_data  = '0;
        wr_rdy    = 1'b0;
        wr_done   = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst && wr_req) begin
                random_wait();
                wr_rdy = 1'b1;
                mem[wr_addr.raw[31:4]] = wr_data;   // stable while the request is up
                @(negedge clk);
                wr_rdy = 1'b0;
                random_wait();
                wr_done = 1'b1;
                @(negedge clk);
                wr_done = 1'b0;
            end else if (!rst && rd_req) begin
                random_wait();
                rd_rdy = 1'b1;
                @(negedge clk);
                rd_rdy = 1'b0;
                random_wait();
                ret_data  = mem.exists(rd_addr.raw[31:4]) ? mem[rd_addr.raw[31:4]] : '0;
                ret_valid = 1'b1;
                @(negedge clk);
                ret_valid = 1'b0;
            end
        end
    end

endmodule
